/* common/isa_consts.svh */
`ifndef ISA_CONSTS_SVH
`define ISA_CONSTS_SVH

// Trigger command and its step register
`define ISA_ADDR_TRIG      32'h0200_1000
`define ISA_ADDR_STEP      32'h0200_1004

// Wait accumulator commands
`define ISA_ADDR_WAIT_CLR  32'h0200_1ffc
`define ISA_ADDR_WAIT_ADD  32'h0200_2000

// Reserved FMR slots
`define ISA_ADDR_FMR0      32'h0200_2fff
`define ISA_ADDR_FMR1      32'h0200_3000
`define ISA_ADDR_FMR2      32'h0200_4000

// Byte distance between lanes of a beat
`define ISA_LANE_STRIDE    4

// Eight queued beats
`define ISA_FIFO_DEPTH_LOG2 3

// Wait-add payload width, zero-extended
`define ISA_WAIT_ADD_BITS  24

`endif

/* common/isa_types_pkg.sv */
package isa_types_pkg;

	////////////////////////////////////////
	// Address and data widths
	////////////////////////////////////////

	// Low 32 bits of the bus address, upper byte dropped
	typedef logic [31:0] isa_addr_t;

	// One instruction word
	typedef logic [31:0] isa_data_t;

	// Byte enables of a single word
	typedef logic [3:0] isa_lane_mask_t;

	// Full bus beat, four words with lane 0 in the low bits
	typedef logic [127:0] isa_beat_data_t;
	typedef logic [15:0] isa_beat_mask_t;

	////////////////////////////////////////
	// Queued and outgoing words
	////////////////////////////////////////

	// FIFO entry {base address, beat data, beat mask}
	typedef logic [$bits(isa_addr_t) + $bits(isa_beat_data_t) + $bits(isa_beat_mask_t) - 1:0]
		isa_entry_t;

	// Outgoing command {address, value}
	typedef logic [63:0] tx_word_t;

endpackage

/* common/isa_cmd_pkg.sv */
package isa_cmd_pkg;

	////////////////////////////////////////
	// Command classes
	////////////////////////////////////////

	// Decoder view of one full-mask word
	typedef enum logic [2:0] {
		TRIG,
		STEP,
		WAIT_CLR,
		WAIT_ADD,
		// FMR slots, decoded but ignored
		RESERVED,
		// Unknown address or no word this cycle
		NONE
	} isa_cmd_e;

	////////////////////////////////////////
	// Unpacker FSM
	////////////////////////////////////////

	// IDLE waits for an entry, EMIT walks its lanes
	typedef enum logic {
		IDLE,
		EMIT
	} unpack_state_e;

endpackage

/* isa_capturer/isa_capturer.sv */
`timescale 1ns/1ns

module isa_capturer (
	input  logic                          I_rst_n,
	input  logic                          wr_clk,
	input  logic                          wr_en,
	input  isa_types_pkg::isa_beat_mask_t ram_en,
	input  isa_types_pkg::isa_beat_data_t wdata,
	input  logic [39:0]                   waddr,
	input  logic                          full,
	output logic                          push,
	output isa_types_pkg::isa_entry_t     push_entry,
	output logic                          overflow
);

	import isa_types_pkg::*;

	isa_addr_t wr_base;
	logic      beat_live;

	// Bits 39:32 never reach the decoder
	assign wr_base = waddr[31:0];

	// Beat with at least one byte enabled
	assign beat_live = wr_en & (|ram_en);

	////////////////////////////////////////
	// Push strobe and sticky overflow
	////////////////////////////////////////

	always_ff @(posedge wr_clk or negedge I_rst_n) begin
		if (!I_rst_n) begin
			push     <= 1'b0;
			overflow <= 1'b0;
		end else begin
			push <= beat_live & ~full;
			// Lost beat, held until reset
			if (beat_live && full) begin
				overflow <= 1'b1;
			end
		end
	end

	// Entry register, loaded only for accepted beats
	always_ff @(posedge wr_clk) begin
		if (beat_live && !full) begin
			push_entry <= {wr_base, wdata, ram_en};
		end
	end

endmodule

/* isa_capturer/isa_async_fifo.sv */
`timescale 1ns/1ns

module isa_async_fifo #(
	parameter int WIDTH      = 176,
	parameter int DEPTH_LOG2 = 3
) (
	input  logic             I_rst_n,
	input  logic             wr_clk,
	input  logic             push,
	input  logic [WIDTH-1:0] push_entry,
	output logic             full,
	input  logic             I_rd_clk,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_entry,
	output logic             empty
);

	// One extra pointer bit tells a wrap apart
	localparam int PTR_W = DEPTH_LOG2 + 1;

	// Gray pattern of a pointer one lap ahead
	localparam logic [PTR_W-1:0] FULL_FLIP = PTR_W'(3) << (DEPTH_LOG2 - 1);

	logic [WIDTH-1:0] mem [2**DEPTH_LOG2];

	// Write domain
	logic [PTR_W-1:0] wbin;
	logic [PTR_W-1:0] wgray;
	logic [PTR_W-1:0] wbin_nxt;
	logic [PTR_W-1:0] wgray_nxt;
	logic [PTR_W-1:0] rgray_w1;
	logic [PTR_W-1:0] rgray_w2;
	logic             wfull_q;
	logic             w_inc;

	// Read domain
	logic [PTR_W-1:0] rbin;
	logic [PTR_W-1:0] rgray;
	logic [PTR_W-1:0] rbin_nxt;
	logic [PTR_W-1:0] rgray_nxt;
	logic [PTR_W-1:0] wgray_r1;
	logic [PTR_W-1:0] wgray_r2;
	logic             rempty_q;
	logic             rempty_nxt;
	logic             r_inc;

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////

	assign w_inc     = push & ~wfull_q;
	assign wbin_nxt  = wbin + PTR_W'(w_inc);
	assign wgray_nxt = (wbin_nxt >> 1) ^ wbin_nxt;

	// Looks ahead past the push in flight, so the next beat sees it
	assign full = (wgray_nxt == (rgray_w2 ^ FULL_FLIP));

	always_ff @(posedge wr_clk or negedge I_rst_n) begin
		if (!I_rst_n) begin
			wbin     <= '0;
			wgray    <= '0;
			wfull_q  <= 1'b0;
			rgray_w1 <= '0;
			rgray_w2 <= '0;
		end else begin
			wbin     <= wbin_nxt;
			wgray    <= wgray_nxt;
			wfull_q  <= full;
			// Two-flop sync of read pointer
			rgray_w1 <= rgray;
			rgray_w2 <= rgray_w1;
		end
	end

	always_ff @(posedge wr_clk) begin
		if (w_inc) begin
			mem[wbin[DEPTH_LOG2-1:0]] <= push_entry;
		end
	end

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////

	assign r_inc      = pop & ~rempty_q;
	assign rbin_nxt   = rbin + PTR_W'(r_inc);
	assign rgray_nxt  = (rbin_nxt >> 1) ^ rbin_nxt;
	assign rempty_nxt = (rgray_nxt == wgray_r2);

	assign empty = rempty_q;

	// Head entry shows without a pop
	assign pop_entry = mem[rbin[DEPTH_LOG2-1:0]];

	always_ff @(posedge I_rd_clk or negedge I_rst_n) begin
		if (!I_rst_n) begin
			rbin     <= '0;
			rgray    <= '0;
			rempty_q <= 1'b1;
			wgray_r1 <= '0;
			wgray_r2 <= '0;
		end else begin
			rbin     <= rbin_nxt;
			rgray    <= rgray_nxt;
			rempty_q <= rempty_nxt;
			// Two-flop sync of write pointer
			wgray_r1 <= wgray;
			wgray_r2 <= wgray_r1;
		end
	end

endmodule

/* isa_capturer/isa_word_unpacker.sv */
`timescale 1ns/1ns
`include "isa_consts.svh"

module isa_word_unpacker (
	input  logic                          I_rd_clk,
	input  logic                          I_rst_n,
	input  logic                          empty,
	input  isa_types_pkg::isa_entry_t     pop_entry,
	output logic                          pop,
	input  logic                          tx_ready,
	output logic                          word_valid,
	output isa_types_pkg::isa_addr_t      word_addr,
	output isa_types_pkg::isa_data_t      word_data,
	output isa_types_pkg::isa_lane_mask_t word_mask
);

	import isa_types_pkg::*;
	import isa_cmd_pkg::*;

	unpack_state_e  state;
	isa_addr_t      ent_addr;
	isa_beat_data_t ent_data;
	isa_beat_mask_t ent_mask;
	isa_beat_mask_t head_mask;
	logic [3:0]     lane_nz;
	logic [3:0]     lane_pend;
	logic [3:0]     lane_pend_nxt;
	logic [1:0]     lane_sel;

	// Take the head only when words can leave, so entries stay queued
	assign pop = (state == IDLE) & ~empty & tx_ready;

	// Mask sits in the low bits of the entry
	assign head_mask = pop_entry[$bits(isa_beat_mask_t)-1:0];

	always_comb begin : head_lanes
		for (int i = 0; i < 4; i++) begin
			lane_nz[i] = |head_mask[i*$bits(isa_lane_mask_t) +: $bits(isa_lane_mask_t)];
		end
	end

	// Lowest lane still pending
	always_comb begin : pick_lane
		lane_sel = 2'd0;
		for (int i = 3; i >= 0; i--) begin
			if (lane_pend[i]) begin
				lane_sel = 2'(i);
			end
		end
	end

	assign lane_pend_nxt = lane_pend & ~(4'b0001 << lane_sel);

	////////////////////////////////////////
	// Lane walk
	////////////////////////////////////////

	always_ff @(posedge I_rd_clk or negedge I_rst_n) begin
		if (!I_rst_n) begin
			state      <= IDLE;
			lane_pend  <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (pop) begin
						state     <= EMIT;
						lane_pend <= lane_nz;
					end
				end
				EMIT: begin
					// Stall in place while tx_ready is low
					if (tx_ready) begin
						word_valid <= 1'b1;
						lane_pend  <= lane_pend_nxt;
						if (lane_pend_nxt == '0) begin
							state <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Latched entry and the word being issued
	always_ff @(posedge I_rd_clk) begin
		if (pop) begin
			{ent_addr, ent_data, ent_mask} <= pop_entry;
		end
		if (state == EMIT && tx_ready) begin
			word_addr <= ent_addr + isa_addr_t'(lane_sel * `ISA_LANE_STRIDE);
			word_data <= ent_data[lane_sel*$bits(isa_data_t) +: $bits(isa_data_t)];
			word_mask <= ent_mask[lane_sel*$bits(isa_lane_mask_t) +: $bits(isa_lane_mask_t)];
		end
	end

endmodule

/* rtl/isa_decode.sv */
`timescale 1ns/1ns
`include "isa_consts.svh"

module isa_decode (
	input  logic                          I_rd_clk,
	input  logic                          I_rst_n,
	input  logic                          word_valid,
	input  isa_types_pkg::isa_addr_t      word_addr,
	input  isa_types_pkg::isa_data_t      word_data,
	input  isa_types_pkg::isa_lane_mask_t word_mask,
	output logic                          trig,
	output isa_types_pkg::isa_data_t      trig_num,
	output isa_types_pkg::isa_data_t      trig_step,
	output logic                          tx_en,
	output isa_types_pkg::tx_word_t       tx_data
);

	import isa_types_pkg::*;
	import isa_cmd_pkg::*;

	isa_cmd_e  cmd;
	isa_data_t wait_acc;
	isa_data_t wait_inc;
	isa_data_t wait_sum;

	////////////////////////////////////////
	// Command classification
	////////////////////////////////////////

	always_comb begin : classify
		cmd = NONE;
		// Only words with every byte enabled count
		if (word_valid && (&word_mask)) begin
			case (word_addr)
				`ISA_ADDR_TRIG:     cmd = TRIG;
				`ISA_ADDR_STEP:     cmd = STEP;
				`ISA_ADDR_WAIT_CLR: cmd = WAIT_CLR;
				`ISA_ADDR_WAIT_ADD: cmd = WAIT_ADD;
				`ISA_ADDR_FMR0,
				`ISA_ADDR_FMR1,
				`ISA_ADDR_FMR2:     cmd = RESERVED;
				default:            cmd = NONE;
			endcase
		end
	end

	// Low data bits, zero-extended, feed both accumulator and tx word
	assign wait_inc = isa_data_t'(word_data[`ISA_WAIT_ADD_BITS-1:0]);
	assign wait_sum = wait_acc + wait_inc;

	////////////////////////////////////////
	// Registered outputs
	////////////////////////////////////////

	always_ff @(posedge I_rd_clk or negedge I_rst_n) begin
		if (!I_rst_n) begin
			trig      <= 1'b0;
			trig_num  <= '0;
			trig_step <= '0;
			tx_en     <= 1'b0;
			tx_data   <= '0;
			wait_acc  <= '0;
		end else begin
			// Strobes fall unless a command raises them
			trig  <= 1'b0;
			tx_en <= 1'b0;
			case (cmd)
				TRIG: begin
					trig     <= 1'b1;
					trig_num <= word_data;
					wait_acc <= '0;
					tx_data  <= {word_addr, word_data};
					tx_en    <= 1'b1;
				end
				STEP: begin
					// Step is only stored, never forwarded
					trig_step <= word_data;
				end
				WAIT_CLR: begin
					wait_acc <= '0;
					tx_data  <= {word_addr, isa_data_t'(0)};
					tx_en    <= 1'b1;
				end
				WAIT_ADD: begin
					wait_acc <= wait_sum;
					tx_data  <= {word_addr, wait_sum};
					tx_en    <= 1'b1;
				end
				// Reserved slots and unknown addresses are no-ops
				default: begin
				end
			endcase
		end
	end

endmodule

/* rtl/isa_decode_top.sv */
`timescale 1ns/1ns
`include "isa_consts.svh"

module isa_decode_top (
	input  logic                          wr_clk,
	input  logic                          I_rd_clk,
	input  logic                          I_rst_n,
	input  logic                          wr_en,
	input  isa_types_pkg::isa_beat_mask_t ram_en,
	input  isa_types_pkg::isa_beat_data_t wdata,
	input  logic [39:0]                   waddr,
	input  logic                          tx_ready,
	output logic                          trig,
	output isa_types_pkg::isa_data_t      trig_num,
	output isa_types_pkg::isa_data_t      trig_step,
	output logic                          tx_en,
	output isa_types_pkg::tx_word_t       tx_data,
	output logic                          overflow
);

	import isa_types_pkg::*;

	// Write domain to FIFO
	logic       push;
	isa_entry_t push_entry;
	logic       full;

	// FIFO to read domain
	logic       pop;
	isa_entry_t pop_entry;
	logic       empty;

	// Unpacked words
	logic           word_valid;
	isa_addr_t      word_addr;
	isa_data_t      word_data;
	isa_lane_mask_t word_mask;

	////////////////////////////////////////
	// Write clock
	////////////////////////////////////////

	isa_capturer u_isa_capturer (
		.I_rst_n    (I_rst_n),
		.wr_clk     (wr_clk),
		.wr_en      (wr_en),
		.ram_en     (ram_en),
		.wdata      (wdata),
		.waddr      (waddr),
		.full       (full),
		.push       (push),
		.push_entry (push_entry),
		.overflow   (overflow)
	);

	// Crossing into I_rd_clk
	isa_async_fifo #(
		.WIDTH      ($bits(isa_entry_t)),
		.DEPTH_LOG2 (`ISA_FIFO_DEPTH_LOG2)
	) u_isa_async_fifo (
		.I_rst_n    (I_rst_n),
		.wr_clk     (wr_clk),
		.push       (push),
		.push_entry (push_entry),
		.full       (full),
		.I_rd_clk   (I_rd_clk),
		.pop        (pop),
		.pop_entry  (pop_entry),
		.empty      (empty)
	);

	////////////////////////////////////////
	// Read clock
	////////////////////////////////////////

	isa_word_unpacker u_isa_word_unpacker (
		.I_rd_clk   (I_rd_clk),
		.I_rst_n    (I_rst_n),
		.empty      (empty),
		.pop_entry  (pop_entry),
		.pop        (pop),
		.tx_ready   (tx_ready),
		.word_valid (word_valid),
		.word_addr  (word_addr),
		.word_data  (word_data),
		.word_mask  (word_mask)
	);

	isa_decode u_isa_decode (
		.I_rd_clk   (I_rd_clk),
		.I_rst_n    (I_rst_n),
		.word_valid (word_valid),
		.word_addr  (word_addr),
		.word_data  (word_data),
		.word_mask  (word_mask),
		.trig       (trig),
		.trig_num   (trig_num),
		.trig_step  (trig_step),
		.tx_en      (tx_en),
		.tx_data    (tx_data)
	);

endmodule

/* sim/tb_isa_decode.sv */
`timescale 1ns/1ns
`include "isa_consts.svh"

module tb_isa_decode;

	import isa_types_pkg::*;

	// Test budgets in ns, the watchdog allows twice their sum
	localparam int T_RESET   = 300;
	localparam int T_TRIG    = 800;
	localparam int T_WAIT    = 1000;
	localparam int T_FILTER  = 1500;
	localparam int T_BACKP   = 2500;
	localparam int RUN_LIMIT = 2 * (T_RESET + T_TRIG + T_WAIT + T_FILTER + T_BACKP);

	// Read-clock cycles to wait for outputs, then for stragglers
	localparam int DRAIN_CYCLES  = 100;
	localparam int SETTLE_CYCLES = 8;

	logic           wr_clk;
	logic           I_rd_clk;
	logic           I_rst_n;
	logic           wr_en;
	isa_beat_mask_t ram_en;
	isa_beat_data_t wdata;
	logic [39:0]    waddr;
	logic           tx_ready;
	logic           trig;
	isa_data_t      trig_num;
	isa_data_t      trig_step;
	logic           tx_en;
	tx_word_t       tx_data;
	logic           overflow;

	// Reference model state and expected outputs
	tx_word_t  exp_tx[$];
	isa_data_t exp_trig[$];
	isa_data_t model_acc;
	isa_data_t model_step;

	int seed        = 3493;
	int err_count   = 0;
	int check_count = 0;
	int test_count  = 0;

	initial begin
		wr_clk = 1'b0;
		forever #5 wr_clk = ~wr_clk;
	end

	initial begin
		I_rd_clk = 1'b0;
		forever #4 I_rd_clk = ~I_rd_clk;
	end

	isa_decode_top u_isa_decode_top (
		.wr_clk    (wr_clk),
		.I_rd_clk  (I_rd_clk),
		.I_rst_n   (I_rst_n),
		.wr_en     (wr_en),
		.ram_en    (ram_en),
		.wdata     (wdata),
		.waddr     (waddr),
		.tx_ready  (tx_ready),
		.trig      (trig),
		.trig_num  (trig_num),
		.trig_step (trig_step),
		.tx_en     (tx_en),
		.tx_data   (tx_data),
		.overflow  (overflow)
	);

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_tx(input tx_word_t got, input tx_word_t exp, input string what);
		check_count++;
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_data(input isa_data_t got, input isa_data_t exp, input string what);
		check_count++;
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		check_count++;
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
			err_count++;
		end
	endtask

	////////////////////////////////////////
	// Reference model and stimulus
	////////////////////////////////////////

	// Decoder rules applied lane by lane, in lane order
	task automatic model_beat(input isa_addr_t base, input isa_beat_data_t data,
		input isa_beat_mask_t mask);
		isa_addr_t addr;
		isa_data_t word;
		for (int i = 0; i < 4; i++) begin
			addr = base + isa_addr_t'(i * `ISA_LANE_STRIDE);
			word = data[i*32 +: 32];
			// Only full byte enables make a command
			if (mask[i*4 +: 4] == 4'hf) begin
				case (addr)
					`ISA_ADDR_TRIG: begin
						exp_trig.push_back(word);
						exp_tx.push_back({addr, word});
						model_acc = '0;
					end
					`ISA_ADDR_STEP: model_step = word;
					`ISA_ADDR_WAIT_CLR: begin
						model_acc = '0;
						exp_tx.push_back({addr, 32'h0});
					end
					`ISA_ADDR_WAIT_ADD: begin
						model_acc = model_acc + {8'h00, word[23:0]};
						exp_tx.push_back({addr, model_acc});
					end
					default: begin
					end
				endcase
			end
		end
	endtask

	// One beat for one wr_clk cycle, upper address byte is junk on purpose
	task automatic write_beat(input isa_addr_t base, input isa_data_t w0, input isa_data_t w1,
		input isa_data_t w2, input isa_data_t w3, input isa_beat_mask_t mask, input bit modeled);
		isa_beat_data_t data;
		data = {w3, w2, w1, w0};
		if (modeled) begin
			model_beat(base, data, mask);
		end
		@(posedge wr_clk);
		#1;
		wr_en  = 1'b1;
		ram_en = mask;
		wdata  = data;
		waddr  = {8'ha5, base};
		@(posedge wr_clk);
		#1;
		wr_en  = 1'b0;
		ram_en = '0;
	endtask

	task automatic set_ready(input logic value);
		@(posedge I_rd_clk);
		#1;
		tx_ready = value;
	endtask

	// Wait until the monitor has seen every expected output
	task automatic wait_drain(input string what);
		int n;
		n = 0;
		while ((exp_tx.size() != 0 || exp_trig.size() != 0) && n < DRAIN_CYCLES) begin
			@(posedge I_rd_clk);
			n++;
		end
		if (exp_tx.size() != 0 || exp_trig.size() != 0) begin
			$display("%s: timed out with %0d tx words and %0d triggers never seen",
				what, exp_tx.size(), exp_trig.size());
			err_count++;
			exp_tx.delete();
			exp_trig.delete();
		end
		// Room for trailing lanes and any stray output
		repeat (SETTLE_CYCLES) @(posedge I_rd_clk);
	endtask

	task automatic end_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, err_count - errs_before);
		end
	endtask

	////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////

	// Sampled on the falling edge, away from the update edge
	always @(negedge I_rd_clk) begin : monitor
		tx_word_t  exp_word;
		isa_data_t exp_num;
		if (I_rst_n) begin
			if (tx_en) begin
				if (exp_tx.size() == 0) begin
					$display("Unexpected tx_en at %0t ns with tx_data %h", $time, tx_data);
					err_count++;
				end else begin
					exp_word = exp_tx.pop_front();
					check_tx(tx_data, exp_word, "tx_data");
				end
			end
			if (trig) begin
				if (exp_trig.size() == 0) begin
					$display("Unexpected trig at %0t ns with trig_num %h", $time, trig_num);
					err_count++;
				end else begin
					exp_num = exp_trig.pop_front();
					check_data(trig_num, exp_num, "trig_num");
				end
			end
		end
	end

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset();
		int e0;
		e0 = err_count;
		// Idle stretch, the monitor flags any strobe
		repeat (10) @(posedge I_rd_clk);
		@(negedge I_rd_clk);
		check_flag(trig, 1'b0, "trig after reset");
		check_flag(tx_en, 1'b0, "tx_en after reset");
		check_flag(overflow, 1'b0, "overflow after reset");
		check_data(trig_num, '0, "trig_num after reset");
		check_data(trig_step, '0, "trig_step after reset");
		check_tx(tx_data, '0, "tx_data after reset");
		end_test("reset", e0);
	endtask

	task automatic test_trig_step();
		int        e0;
		isa_data_t d0;
		isa_data_t d1;
		e0 = err_count;
		d0 = $random(seed);
		d1 = $random(seed);
		// Lane 0 trigger, lane 1 step
		write_beat(`ISA_ADDR_TRIG, d0, d1, '0, '0, 16'h00ff, 1'b1);
		wait_drain("trig_step");
		@(negedge I_rd_clk);
		check_data(trig_num, d0, "trig_num held");
		check_data(trig_step, d1, "trig_step");
		end_test("trig_step", e0);
	endtask

	task automatic test_wait();
		int        e0;
		isa_data_t a0;
		isa_data_t a1;
		e0 = err_count;
		a0 = $random(seed);
		a1 = $random(seed);
		// Nonzero sum first, so the clear has something to drop
		write_beat(`ISA_ADDR_WAIT_ADD, a1, '0, '0, '0, 16'h000f, 1'b1);
		// Lane 3 lands on the wait-clear address
		write_beat(32'h0200_1ff0, a1, a1, a1, a0, 16'hf000, 1'b1);
		write_beat(`ISA_ADDR_WAIT_ADD, a0, '0, '0, '0, 16'h000f, 1'b1);
		write_beat(`ISA_ADDR_WAIT_ADD, a1, '0, '0, '0, 16'h000f, 1'b1);
		wait_drain("wait");
		end_test("wait", e0);
	endtask

	task automatic test_filter();
		int        e0;
		isa_data_t d;
		e0 = err_count;
		d  = $random(seed);
		// Partial trig, zero-mask step, two unknown full lanes
		write_beat(`ISA_ADDR_TRIG, d, d, d, d, 16'hff07, 1'b1);
		// FMR0 in lane 3
		write_beat(32'h0200_2ff3, d, d, d, d, 16'hf000, 1'b1);
		write_beat(`ISA_ADDR_FMR1, d, d, d, d, 16'h00ff, 1'b1);
		write_beat(`ISA_ADDR_FMR2, d, d, d, d, 16'h000f, 1'b1);
		// No byte enabled at all
		write_beat(`ISA_ADDR_TRIG, d, d, d, d, 16'h0000, 1'b1);
		// Marker trigger, any leak above reaches the monitor first
		write_beat(`ISA_ADDR_TRIG, ~d, '0, '0, '0, 16'h000f, 1'b1);
		wait_drain("filter");
		check_data(trig_step, model_step, "trig_step kept");
		end_test("filter", e0);
	endtask

	task automatic test_backpressure();
		int        e0;
		isa_data_t n;
		e0 = err_count;
		set_ready(1'b0);
		// Eight fit, the last two are lost
		for (int i = 0; i < 10; i++) begin
			if (i == 8) begin
				// Empty beat into a full FIFO is not a lost beat
				write_beat(`ISA_ADDR_TRIG, '0, '0, '0, '0, 16'h0000, 1'b1);
				check_flag(overflow, 1'b0, "overflow after empty beat on full FIFO");
			end
			n = $random(seed);
			write_beat(`ISA_ADDR_TRIG, n, '0, '0, '0, 16'h000f, i < 8);
		end
		check_flag(overflow, 1'b1, "overflow after ten beats");
		set_ready(1'b1);
		wait_drain("backpressure");
		check_flag(overflow, 1'b1, "overflow sticky");
		end_test("backpressure", e0);
	endtask

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////

	initial begin
		wr_en      = 1'b0;
		ram_en     = '0;
		wdata      = '0;
		waddr      = '0;
		tx_ready   = 1'b1;
		model_acc  = '0;
		model_step = '0;
		I_rst_n    = 1'b0;
		repeat (10) @(posedge I_rd_clk);
		#1;
		I_rst_n = 1'b1;
		test_reset();
		test_trig_step();
		test_wait();
		test_filter();
		test_backpressure();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Hang guard
	initial begin
		#(RUN_LIMIT);
		$display("Watchdog: run did not finish within %0d ns", RUN_LIMIT);
		$display("Done: errors found");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+common
common/isa_types_pkg.sv
common/isa_cmd_pkg.sv
isa_capturer/isa_capturer.sv
isa_capturer/isa_async_fifo.sv
isa_capturer/isa_word_unpacker.sv
rtl/isa_decode.sv
rtl/isa_decode_top.sv
sim/tb_isa_decode.sv

/* Makefile */
TOP = tb_isa_decode

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f verilog.f -o $(TOP)

# Pass only if the pass message shows up in the output
run: compile
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
